// File: logic/div_macros.svh
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// operand width of the divider, one data word
`define DIV_WIDTH 32

// width of a bit position inside a word, log2 of DIV_WIDTH
`define DIV_POS_WIDTH 5

// worst-case cycles for one division
// load, setup, one step per quotient bit, finish and the ack cycle
`define DIV_MAX_STEPS (`DIV_WIDTH + 4)

// most negative operand value, used for the overflow case
`define DIV_MIN_VALUE {1'b1, {(`DIV_WIDTH-1){1'b0}}}

// all ones, that is minus one in two's complement
`define DIV_MINUS_ONE {`DIV_WIDTH{1'b1}}

`endif

// File: logic/div_data_pkg.sv
`include "div_macros.svh"

package div_data_pkg;

    // request side of the divider
    // both fields are two's complement
    typedef struct packed {
        logic [`DIV_WIDTH-1:0] dividend;
        logic [`DIV_WIDTH-1:0] divisor;
    } div_operands_t;

    // response side of the divider
    // quotient truncates toward zero, remainder follows the dividend sign
    typedef struct packed {
        logic [`DIV_WIDTH-1:0] quotient;
        logic [`DIV_WIDTH-1:0] remainder;
        // divisor zero or most negative over minus one
        logic                  overflow;
    } div_result_t;

    // sign bit helper shared by the datapath
    function automatic logic div_sign(input logic [`DIV_WIDTH-1:0] value);
        div_sign = value[`DIV_WIDTH-1];
    endfunction

endpackage

// File: logic/div_ctrl_pkg.sv
package div_ctrl_pkg;

    // controller phases, one state per cycle
    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        ITERATE,
        FINISH,
        HOLD_ACK
    } div_state_t;

    // per-cycle command to the datapath
    typedef struct packed {
        // capture magnitudes, signs and special cases
        logic load;
        // seed the partial remainder and clear the quotient
        logic setup;
        // one compare and subtract at the current position
        logic step;
        // write the signed result
        logic finish;
    } div_cmd_t;

endpackage

// File: logic/div_msb_detect.sv
`timescale 1ns/1ns
`include "div_macros.svh"

// leading-one position of an unsigned magnitude
module div_msb_detect (
    input  logic [`DIV_WIDTH-1:0]     value,
    output logic [`DIV_POS_WIDTH-1:0] pos,
    output logic                      zero
);

    // scan upward so the highest set bit is written last
    always_comb begin
        pos = '0;
        for (int i = 0; i < `DIV_WIDTH; i++) begin
            if (value[i]) begin
                pos = `DIV_POS_WIDTH'(i);
            end
        end
    end

    // pos reads zero for both bit zero and an empty word
    assign zero = ~|value;

endmodule

// File: logic/div_shift_counter.sv
`timescale 1ns/1ns
`include "div_macros.svh"

// trial shift position for the long division
module div_shift_counter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      load,
    input  logic                      step,
    input  logic [`DIV_POS_WIDTH-1:0] load_pos,
    output logic [`DIV_POS_WIDTH-1:0] pos,
    output logic                      last
);

    // load wins over step if both arrive together
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pos <= '0;
        end else if (load) begin
            pos <= load_pos;
        end else if (step) begin
            pos <= pos - 1'b1;
        end
    end

    // bit zero is the final quotient bit
    assign last = (pos == '0);

endmodule

// File: logic/div_fsm.sv
`timescale 1ns/1ns

// handshake and sequencing for the divider
module div_fsm import div_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     req,
    output logic     ack,
    input  logic     special,
    input  logic     last,
    output div_cmd_t cmd,
    output logic     count_load,
    output logic     count_step
);

    div_state_t state;
    div_state_t state_next;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        cmd        = '0;
        count_load = 1'b0;
        count_step = 1'b0;

        case (state)
            IDLE: begin
                // operands are stable while req is high
                if (req) begin
                    cmd.load   = 1'b1;
                    state_next = SETUP;
                end
            end

            SETUP: begin
                cmd.setup = 1'b1;
                // special results need no iterations
                if (special) begin
                    state_next = FINISH;
                end else begin
                    count_load = 1'b1;
                    state_next = ITERATE;
                end
            end

            ITERATE: begin
                cmd.step = 1'b1;
                if (last) begin
                    state_next = FINISH;
                end else begin
                    count_step = 1'b1;
                end
            end

            FINISH: begin
                cmd.finish = 1'b1;
                state_next = HOLD_ACK;
            end

            HOLD_ACK: begin
                // result frozen until the requester lets go
                if (!req) begin
                    state_next = IDLE;
                end
            end

            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // ack comes straight from the state register, no glitches
    assign ack = (state == HOLD_ACK);

endmodule

// File: logic/div_datapath.sv
`timescale 1ns/1ns
`include "div_macros.svh"

// magnitudes, partial remainder, quotient and sign handling
module div_datapath import div_data_pkg::*, div_ctrl_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  div_cmd_t                  cmd,
    input  div_operands_t             operands,
    input  logic [`DIV_POS_WIDTH-1:0] pos,
    output logic [`DIV_WIDTH-1:0]     mag_a,
    output logic [`DIV_WIDTH-1:0]     mag_b,
    output logic                      special,
    output div_result_t               result
);

    logic                  sign_a;
    logic                  sign_b;
    logic                  spec_zero;
    logic                  spec_one;
    logic                  spec_ovf;
    logic [`DIV_WIDTH-1:0] prem;
    logic [`DIV_WIDTH-1:0] quo;
    logic [`DIV_WIDTH-1:0] shifted;
    logic                  sub_ok;

    // special cases are decided once, from the raw operands
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            spec_zero <= 1'b0;
            spec_one  <= 1'b0;
            spec_ovf  <= 1'b0;
        end else if (cmd.load) begin
            spec_zero <= (operands.divisor == '0);
            spec_one  <= (operands.divisor == `DIV_WIDTH'(1));
            spec_ovf  <= (operands.dividend == `DIV_MIN_VALUE) &&
                         (operands.divisor == `DIV_MINUS_ONE);
        end
    end

    assign special = spec_zero | spec_one | spec_ovf;

    // the leading-one skip keeps the shifted divisor inside the word
    assign shifted = mag_b << pos;
    assign sub_ok  = (prem >= shifted);

    always_ff @(posedge clk) begin
        if (cmd.load) begin
            sign_a <= div_sign(operands.dividend);
            sign_b <= div_sign(operands.divisor);
            // most negative value maps to itself, which is the right magnitude
            mag_a  <= div_sign(operands.dividend) ? -operands.dividend : operands.dividend;
            mag_b  <= div_sign(operands.divisor) ? -operands.divisor : operands.divisor;
        end

        if (cmd.setup) begin
            prem <= mag_a;
            quo  <= '0;
        end else if (cmd.step && sub_ok) begin
            prem     <= prem - shifted;
            quo[pos] <= 1'b1;
        end

        if (cmd.finish) begin
            if (special) begin
                // every special case returns the dividend itself
                result.quotient  <= sign_a ? -mag_a : mag_a;
                result.remainder <= '0;
                result.overflow  <= spec_zero | spec_ovf;
            end else begin
                result.quotient  <= (sign_a ^ sign_b) ? -quo : quo;
                result.remainder <= sign_a ? -prem : prem;
                result.overflow  <= 1'b0;
            end
        end
    end

endmodule

// File: logic/div_unit.sv
`timescale 1ns/1ns
`include "div_macros.svh"

// multi-cycle signed divider behind a four-phase req/ack handshake
module div_unit import div_data_pkg::*, div_ctrl_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          req,
    output logic          ack,
    input  div_operands_t operands,
    output div_result_t   result
);

    div_cmd_t                  cmd;
    logic                      count_load;
    logic                      count_step;
    logic                      last;
    logic                      special;
    logic [`DIV_POS_WIDTH-1:0] pos;
    logic [`DIV_POS_WIDTH-1:0] load_pos;
    logic [`DIV_WIDTH-1:0]     mag_a;
    logic [`DIV_WIDTH-1:0]     mag_b;
    logic [`DIV_POS_WIDTH-1:0] pos_a;
    logic [`DIV_POS_WIDTH-1:0] pos_b;
    logic                      zero_a;
    logic                      zero_b;

    div_fsm fsm0 (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .ack        (ack),
        .special    (special),
        .last       (last),
        .cmd        (cmd),
        .count_load (count_load),
        .count_step (count_step)
    );

    div_msb_detect msb_a0 (.value(mag_a), .pos(pos_a), .zero(zero_a));
    div_msb_detect msb_b0 (.value(mag_b), .pos(pos_b), .zero(zero_b));

    // start at the first quotient bit that can be set
    // divisor above dividend clamps to a single step at bit zero
    assign load_pos = (zero_a || zero_b || (pos_b > pos_a)) ? '0 : pos_a - pos_b;

    div_shift_counter counter0 (
        .clk      (clk),
        .reset    (reset),
        .load     (count_load),
        .step     (count_step),
        .load_pos (load_pos),
        .pos      (pos),
        .last     (last)
    );

    div_datapath datapath0 (
        .clk      (clk),
        .reset    (reset),
        .cmd      (cmd),
        .operands (operands),
        .pos      (pos),
        .mag_a    (mag_a),
        .mag_b    (mag_b),
        .special  (special),
        .result   (result)
    );

endmodule

// File: test/div_unit_assert.sv
`timescale 1ns/1ns

// handshake and shift counter properties of the divider
module div_unit_assert (
    input logic clk,
    input logic reset,
    input logic req,
    input logic ack,
    input logic count_load,
    input logic last
);

    // count of failed properties
    int failures = 0;

    // ack only answers a request that was pending on the cycle before
    property ack_needs_req;
        @(posedge clk) disable iff (reset) $rose(ack) |-> $past(req);
    endproperty

    // result is held for as long as the requester keeps req high
    property ack_held_with_req;
        @(posedge clk) disable iff (reset) (ack && req) |=> ack;
    endproperty

    // ack falls one cycle after req is seen low
    property ack_released;
        @(posedge clk) disable iff (reset) (ack && !req) |=> !ack;
    endproperty

    // bit zero is the final step, the counter stays there until the next load
    property no_step_at_zero;
        @(posedge clk) disable iff (reset) (last && !count_load) |=> last;
    endproperty

    ack_needs_req_a: assert property (ack_needs_req)
        else begin
            $error("ack rose without req");
            failures++;
        end

    ack_held_a: assert property (ack_held_with_req)
        else begin
            $error("ack dropped while req high");
            failures++;
        end

    ack_released_a: assert property (ack_released)
        else begin
            $error("ack stuck after req fell");
            failures++;
        end

    no_step_a: assert property (no_step_at_zero)
        else begin
            $error("counter stepped at zero");
            failures++;
        end

endmodule

// File: test/div_unit_tb.sv
`timescale 1ns/1ns
`include "div_macros.svh"

module div_unit_tb import div_data_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 200;
    // upper bound on the directed table size
    localparam int TABLE_BOUND  = 32;
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + (TABLE_BOUND + N_RANDOM) * (`DIV_MAX_STEPS + 8);

    typedef struct packed {
        logic [`DIV_WIDTH-1:0] dividend;
        logic [`DIV_WIDTH-1:0] divisor;
        logic [`DIV_WIDTH-1:0] quotient;
        logic [`DIV_WIDTH-1:0] remainder;
        logic                  overflow;
    } vector_t;

    logic          clk;
    logic          reset;
    logic          req;
    logic          ack;
    div_operands_t operands;
    div_result_t   result;

    vector_t vectors[$];
    int      value_errors;
    int      protocol_errors;
    integer  seed;

    div_unit dut0 (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .ack      (ack),
        .operands (operands),
        .result   (result)
    );

    bind div_unit div_unit_assert assert0 (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .ack        (ack),
        .count_load (count_load),
        .last       (last)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic add_vector(input logic [`DIV_WIDTH-1:0] a, input logic [`DIV_WIDTH-1:0] b,
                              input logic [`DIV_WIDTH-1:0] q, input logic [`DIV_WIDTH-1:0] r,
                              input logic ovf);
        vectors.push_back({a, b, q, r, ovf});
    endtask

    // directed cases, values worked out for a 32-bit word
    task automatic fill_table();
        add_vector( 32'sd7,       32'sd2,      32'sd3,       32'sd1,  1'b0);
        add_vector(-32'sd7,       32'sd2,     -32'sd3,      -32'sd1,  1'b0);
        add_vector( 32'sd7,      -32'sd2,     -32'sd3,       32'sd1,  1'b0);
        add_vector(-32'sd7,      -32'sd2,      32'sd3,      -32'sd1,  1'b0);
        add_vector( 32'sd1000000, 32'sd7,      32'sd142857,  32'sd1,  1'b0);
        add_vector( 32'sd100,     32'sd7,      32'sd14,      32'sd2,  1'b0);
        add_vector( 32'h7fff_ffff, 32'sd3,     32'h2aaa_aaaa, 32'sd1, 1'b0);
        add_vector( 32'h8000_0000, 32'sd3,     32'hd555_5556, -32'sd2, 1'b0);
        add_vector( 32'h8000_0000, 32'sd2,     32'hc000_0000, 32'sd0, 1'b0);
        // zero divisor returns the dividend
        add_vector( 32'sd100,     32'sd0,      32'sd100,     32'sd0,  1'b1);
        add_vector(-32'sd5,       32'sd0,     -32'sd5,       32'sd0,  1'b1);
        add_vector( 32'sd12345,   32'sd1,      32'sd12345,   32'sd0,  1'b0);
        add_vector(-32'sd12345,   32'sd1,     -32'sd12345,   32'sd0,  1'b0);
        add_vector( 32'sd9,      -32'sd1,     -32'sd9,       32'sd0,  1'b0);
        // most negative over minus one wraps
        add_vector( 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 32'sd0, 1'b1);
        add_vector( 32'sd3,       32'sd10,     32'sd0,       32'sd3,  1'b0);
        add_vector(-32'sd3,       32'sd10,     32'sd0,      -32'sd3,  1'b0);
        add_vector( 32'sd5,       32'h8000_0000, 32'sd0,     32'sd5,  1'b0);
        add_vector( 32'sd42,      32'sd42,     32'sd1,       32'sd0,  1'b0);
        add_vector(-32'sd42,      32'sd42,    -32'sd1,       32'sd0,  1'b0);
        add_vector( 32'h8000_0000, 32'h8000_0000, 32'sd1,    32'sd0,  1'b0);
        add_vector( 32'sd0,       32'sd5,      32'sd0,       32'sd0,  1'b0);
    endtask

    // truncating signed division with the two overflow cases
    function automatic div_result_t reference_divide(input logic [`DIV_WIDTH-1:0] a,
                                                     input logic [`DIV_WIDTH-1:0] b);
        div_result_t r;
        if (b == '0) begin
            r.quotient  = a;
            r.remainder = '0;
            r.overflow  = 1'b1;
        end else if (a == `DIV_MIN_VALUE && b == `DIV_MINUS_ONE) begin
            r.quotient  = a;
            r.remainder = '0;
            r.overflow  = 1'b1;
        end else begin
            r.quotient  = $signed(a) / $signed(b);
            r.remainder = $signed(a) % $signed(b);
            r.overflow  = 1'b0;
        end
        return r;
    endfunction

    // one full four-phase transaction, hold extends the time req stays high
    task automatic divide(input logic [`DIV_WIDTH-1:0] dividend,
                          input logic [`DIV_WIDTH-1:0] divisor,
                          input int hold, output div_result_t res);
        int          cycles;
        div_result_t held;
        @(negedge clk);
        operands.dividend = dividend;
        operands.divisor  = divisor;
        req               = 1'b1;
        @(negedge clk);
        cycles = 1;
        while (!ack) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles > `DIV_MAX_STEPS) begin
            $display("ack took %0d cycles, more than the worst case of %0d",
                     cycles, `DIV_MAX_STEPS);
            protocol_errors++;
        end
        held = result;
        repeat (hold) begin
            @(negedge clk);
            if (!ack) begin
                $display("ack dropped at %0t while req was still high", $time);
                protocol_errors++;
            end
            if (result !== held) begin
                $display("ERR %0t result expected %h actual %h", $time, held, result);
                value_errors++;
            end
        end
        req = 1'b0;
        @(negedge clk);
        if (ack) begin
            $display("ack still high at %0t, one cycle after req dropped", $time);
            protocol_errors++;
        end
        res = held;
    endtask

    task automatic check_result(input vector_t v, input div_result_t res);
        logic [`DIV_WIDTH-1:0] rebuilt;
        rebuilt = $signed(res.quotient) * $signed(v.divisor) + $signed(res.remainder);
        if (res.quotient !== v.quotient) begin
            $display("ERR %0t quotient expected %h actual %h", $time, v.quotient, res.quotient);
            value_errors++;
        end
        if (res.remainder !== v.remainder) begin
            $display("ERR %0t remainder expected %h actual %h", $time, v.remainder,
                     res.remainder);
            value_errors++;
        end
        if (res.overflow !== v.overflow) begin
            $display("ERR %0t overflow expected %b actual %b", $time, v.overflow, res.overflow);
            value_errors++;
        end
        if (!v.overflow && rebuilt !== v.dividend) begin
            $display("ERR %0t dividend expected %h actual %h", $time, v.dividend, rebuilt);
            value_errors++;
        end
    endtask

    initial begin
        vector_t     v;
        div_result_t res;
        int          shift;
        clk             = 1'b0;
        reset           = 1'b1;
        req             = 1'b0;
        operands        = '0;
        value_errors    = 0;
        protocol_errors = 0;
        seed            = 32'h8eea_56db;
        fill_table();

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (ack) begin
            $display("ack is high after reset");
            protocol_errors++;
        end

        foreach (vectors[i]) begin
            divide(vectors[i].dividend, vectors[i].divisor, i % 4, res);
            check_result(vectors[i], res);
        end

        // random shift makes small divisors and the special cases likely
        for (int n = 0; n < N_RANDOM; n++) begin
            v.dividend = $random(seed);
            v.divisor  = $random(seed);
            shift      = $unsigned($random(seed)) % `DIV_WIDTH;
            v.divisor  = $signed(v.divisor) >>> shift;
            res        = reference_divide(v.dividend, v.divisor);
            v.quotient  = res.quotient;
            v.remainder = res.remainder;
            v.overflow  = res.overflow;
            divide(v.dividend, v.divisor, n % 2, res);
            check_result(v, res);
        end

        $display("errors: %0d value, %0d handshake, %0d assertion",
                 value_errors, protocol_errors, dut0.assert0.failures);
        if (value_errors == 0 && protocol_errors == 0 && dut0.assert0.failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, a transaction never completed",
                 WATCHDOG_CYCLES);
        $display("errors: %0d value, %0d handshake, %0d assertion",
                 value_errors, protocol_errors, dut0.assert0.failures);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+logic
logic/div_data_pkg.sv
logic/div_ctrl_pkg.sv
logic/div_msb_detect.sv
logic/div_shift_counter.sv
logic/div_fsm.sv
logic/div_datapath.sv
logic/div_unit.sv
test/div_unit_assert.sv
test/div_unit_tb.sv

// File: Makefile
# Verilator flow for the divider testbench

VERILATOR ?= verilator
TOP       ?= div_unit_tb
RTL_TOP   ?= div_unit
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= STATUS: PASS

.PHONY: all lint lint_rtl build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

lint_rtl:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)

# the run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
